// ==== verilog/debugPkg.sv ====
`default_nettype none

package debugPkg;

    // ============================================================
    // Widths with a meaning
    // ============================================================
    typedef logic [7:0]  byteT;
    typedef logic [9:0]  memAddrT;
    typedef logic [15:0] memWordT;
    // Remaining count of a reply, up to 256
    typedef logic [8:0]  msgLenT;

    // Sizes
    localparam int memWords   = 1024;
    localparam int fifoDepth  = 8;
    localparam int fifoPtrW   = $clog2(fifoDepth);
    localparam int chunkWords = 127;
    // Count byte of an echo frame comes out as 0xFF
    localparam msgLenT echoLen = 9'd256;

    // Command codes
    localparam byteT cmdNop     = 8'h00;
    localparam byteT cmdLedOff  = 8'h80;
    localparam byteT cmdLedOn   = 8'h81;
    localparam byteT cmdReadMem = 8'h82;

    // ============================================================
    // State machines
    // ============================================================
    typedef enum logic [2:0] {
        ctrlFill,
        ctrlAccept,
        ctrlExecute,
        ctrlReply,
        ctrlReadStart,
        ctrlReadRun,
        ctrlReadSend
    } ctrlStateT;

    typedef enum logic [1:0] {
        frmCmdByte,
        frmCountByte,
        frmWait,
        frmPayload
    } framerStateT;

    // Fill pattern, word a holds a XOR key
    localparam memWordT patternKey = 16'hA5C3;

    function automatic memWordT patternWord(memAddrT a);
        return memWordT'(a) ^ patternKey;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/memReqIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface memReqIf;
    import debugPkg::*;

    // Request side
    logic    reqValid;
    memAddrT addr;
    logic    we;
    memWordT wdata;
    logic    reqReady;

    // Read return, one cycle after accept
    memWordT rdata;
    logic    rdValid;

    modport controller (
        output reqValid, addr, we, wdata,
        input  reqReady, rdata, rdValid
    );

    modport memory (
        input  reqValid, addr, we, wdata,
        output reqReady, rdata, rdValid
    );

endinterface

`default_nettype wire

// ==== verilog/byteFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteFifo (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire                 push,
    input  wire debugPkg::byteT wdata,
    input  wire                 pop,
    output debugPkg::byteT      rdata,
    output logic                full,
    output logic                empty
);
    import debugPkg::*;

    byteT                store [fifoDepth];
    logic [fifoPtrW-1:0] wrPtr;
    logic [fifoPtrW-1:0] rdPtr;
    logic [fifoPtrW:0]   count;
    logic                doPush;
    logic                doPop;

    // Push on full and pop on empty are dropped
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign full  = (count == (fifoPtrW + 1)'(fifoDepth));
    assign empty = (count == '0);
    // Head of queue, no read latency
    assign rdata = store[rdPtr];

    // Storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            store[wrPtr] <= wdata;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/serialShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module serialShifter (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire                 debugCs,
    input  wire                 debugDi,
    output logic                debugDo,
    output logic                inPush,
    output debugPkg::byteT      inData,
    input  wire debugPkg::byteT outData,
    input  wire                 outEmpty,
    output logic                outPop
);
    import debugPkg::*;

    // ============================================================
    // Bit timing
    // ============================================================
    logic [2:0] bitCnt;
    logic       boundary;
    byteT       inShift;
    byteT       inByte;
    byteT       outShift;

    // Eighth bit of a byte is on the pins
    assign boundary = debugCs && (bitCnt == 3'd7);

    // Byte as it stands with the current bit included
    assign inByte = {inShift[6:0], debugDi};

    // MSB first
    assign debugDo = outShift[7];

    // Take the next reply byte only when one is waiting
    assign outPop = boundary && !outEmpty;

    // ============================================================
    // Shift registers
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt   <= '0;
            inShift  <= '0;
            outShift <= '0;
            inPush   <= 1'b0;
        end else begin
            inPush <= 1'b0;
            if (debugCs) begin
                bitCnt  <= bitCnt + 1'b1;
                inShift <= inByte;
                if (boundary) begin
                    // Zero bytes are idle filler from the host
                    inPush   <= (inByte != 8'h00);
                    // Idle link sends zeros
                    outShift <= outEmpty ? 8'h00 : outData;
                end else begin
                    outShift <= outShift << 1;
                end
            end
        end
    end

    // Byte handed to the input queue one cycle after its last bit
    always_ff @(posedge clk) begin
        if (boundary) begin
            inData <= inByte;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/msgFramer.sv ====
`timescale 1ns/1ps
`default_nettype none

module msgFramer (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire debugPkg::byteT   msg,
    input  wire debugPkg::msgLenT msgLen,
    input  wire                   outFull,
    output logic                  msgTake,
    output logic                  outPush,
    output debugPkg::byteT        outData
);
    import debugPkg::*;

    framerStateT state;
    msgLenT      lenMinusOne;

    // Count byte carries the remaining length less one
    assign lenMinusOne = msgLen - 9'd1;

    // ============================================================
    // Byte selection
    // ============================================================
    always_comb begin
        outPush = 1'b0;
        msgTake = 1'b0;
        outData = msg;
        case (state)
            // Nonzero length opens a frame
            frmCmdByte: begin
                outPush = (msgLen != '0) && !outFull;
            end
            frmCountByte: begin
                outData = lenMinusOne[7:0];
                outPush = !outFull;
                msgTake = !outFull;
            end
            frmPayload: begin
                outPush = !outFull;
                msgTake = !outFull;
            end
            // Controller updates msg and msgLen here
            default: begin
                outPush = 1'b0;
            end
        endcase
    end

    // Stalls in place while the output queue is full
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= frmCmdByte;
        end else begin
            case (state)
                frmCmdByte:   if (outPush) state <= frmCountByte;
                frmCountByte: if (outPush) state <= frmWait;
                frmPayload:   if (outPush) state <= frmWait;
                // Frame done once the count runs out
                default:      state <= (msgLen != '0) ? frmPayload : frmCmdByte;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/patternMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module patternMem (
    input  wire         clk,
    input  wire         arstN,
    memReqIf.memory     mem
);
    import debugPkg::*;

    memWordT store [memWords];
    logic    accept;

    // Handshake
    assign accept = mem.reqValid && mem.reqReady;

    // ============================================================
    // Control flags
    // ============================================================
    // Ready comes up right after reset and stays up
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mem.reqReady <= 1'b0;
            mem.rdValid  <= 1'b0;
        end else begin
            mem.reqReady <= 1'b1;
            // One cycle behind the accepted read
            mem.rdValid  <= accept && !mem.we;
        end
    end

    // ============================================================
    // Array and read register
    // ============================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem.we) begin
                store[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= store[mem.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cmdController.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmdController (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire debugPkg::byteT cmd,
    input  wire                 cmdReady,
    output logic                cmdTake,
    output debugPkg::byteT      msg,
    output debugPkg::msgLenT    msgLen,
    input  wire                 msgTake,
    output logic                ledOn,
    memReqIf.controller         mem
);
    import debugPkg::*;

    ctrlStateT   state;
    byteT        cmdReg;
    // Two bytes per word, 254 used at most
    byteT        readBuf [256];
    logic [7:0]  bufLen;
    logic [7:0]  sendIdx;
    logic [7:0]  reqLeft;
    logic [7:0]  recvLeft;
    logic [10:0] wordsLeft;
    logic [7:0]  chunkLen;
    msgLenT      lenMinusOne;

    assign cmdTake     = (state == ctrlAccept) && cmdReady;
    assign lenMinusOne = msgLen - 9'd1;
    // Fill data follows the address
    assign mem.wdata   = patternWord(mem.addr);

    // Words to go before the address wraps
    assign wordsLeft = 11'(memWords) - {1'b0, mem.addr};
    assign chunkLen  = (wordsLeft > 11'(chunkWords)) ? 8'(chunkWords) : wordsLeft[7:0];

    // Read data lands low byte first
    always_ff @(posedge clk) begin
        if (state == ctrlReadRun && mem.rdValid) begin
            readBuf[bufLen]        <= mem.rdata[7:0];
            readBuf[bufLen + 8'd1] <= mem.rdata[15:8];
        end
    end

    // ============================================================
    // Main FSM
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state        <= ctrlFill;
            cmdReg       <= '0;
            msg          <= '0;
            msgLen       <= '0;
            ledOn        <= 1'b0;
            bufLen       <= '0;
            sendIdx      <= '0;
            reqLeft      <= '0;
            recvLeft     <= '0;
            mem.reqValid <= 1'b0;
            mem.addr     <= '0;
            mem.we       <= 1'b0;
        end else begin
            case (state)
                // Write pattern to every word, addr wraps to 0 at the end
                ctrlFill: begin
                    if (!mem.reqValid) begin
                        mem.reqValid <= 1'b1;
                        mem.we       <= 1'b1;
                    end else if (mem.reqReady) begin
                        mem.addr <= mem.addr + 1'b1;
                        if (mem.addr == memAddrT'(memWords - 1)) begin
                            mem.reqValid <= 1'b0;
                            mem.we       <= 1'b0;
                            state        <= ctrlAccept;
                        end
                    end
                end
                ctrlAccept: begin
                    if (cmdTake) begin
                        cmdReg <= cmd;
                        state  <= ctrlExecute;
                    end
                end
                ctrlExecute: begin
                    // Echo frame unless overridden below
                    msg    <= cmdReg;
                    msgLen <= echoLen;
                    state  <= ctrlReply;
                    case (cmdReg)
                        cmdLedOff: ledOn <= 1'b0;
                        cmdLedOn:  ledOn <= 1'b1;
                        // Nop has no reply
                        cmdNop: begin
                            msgLen <= '0;
                            state  <= ctrlAccept;
                        end
                        cmdReadMem: begin
                            msgLen   <= '0;
                            mem.addr <= '0;
                            state    <= ctrlReadStart;
                        end
                        default: ;
                    endcase
                end
                // Echo payload counts down
                ctrlReply: begin
                    if (msgTake) begin
                        msg    <= lenMinusOne[7:0];
                        msgLen <= lenMinusOne;
                        if (msgLen == 9'd1) begin
                            state <= ctrlAccept;
                        end
                    end
                end
                ctrlReadStart: begin
                    mem.reqValid <= 1'b1;
                    reqLeft      <= chunkLen;
                    recvLeft     <= chunkLen;
                    bufLen       <= '0;
                    state        <= ctrlReadRun;
                end
                ctrlReadRun: begin
                    // Issue side
                    if (mem.reqValid && mem.reqReady && reqLeft != '0) begin
                        mem.addr <= mem.addr + 1'b1;
                        reqLeft  <= reqLeft - 8'd1;
                        if (reqLeft == 8'd1) begin
                            mem.reqValid <= 1'b0;
                        end
                    end
                    // Return side, frame opens on the last word
                    if (mem.rdValid) begin
                        bufLen   <= bufLen + 8'd2;
                        recvLeft <= recvLeft - 8'd1;
                        if (recvLeft == 8'd1) begin
                            msg     <= cmdReadMem;
                            msgLen  <= msgLenT'(bufLen) + 9'd3;
                            sendIdx <= '0;
                            state   <= ctrlReadSend;
                        end
                    end
                end
                ctrlReadSend: begin
                    if (msgTake) begin
                        msg     <= readBuf[sendIdx];
                        sendIdx <= sendIdx + 8'd1;
                        msgLen  <= lenMinusOne;
                        // Done once the address has wrapped
                        if (msgLen == 9'd1) begin
                            state <= (mem.addr == '0) ? ctrlAccept : ctrlReadStart;
                        end
                    end
                end
                default: state <= ctrlAccept;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/debugTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugTop (
    input  wire clk,
    input  wire arstN,
    input  wire debugCs,
    input  wire debugDi,
    output wire debugDo,
    output wire ledOn
);
    import debugPkg::*;

    // Link to input queue
    logic   inPush;
    byteT   inData;
    // Input queue to controller
    byteT   cmd;
    logic   cmdTake;
    logic   inEmpty;
    logic   cmdReady;
    // Controller to framer
    byteT   msg;
    msgLenT msgLen;
    logic   msgTake;
    // Framer to output queue to link
    logic   outPush;
    byteT   outWData;
    logic   outFull;
    byteT   outRData;
    logic   outEmpty;
    logic   outPop;

    memReqIf memBus ();

    assign cmdReady = !inEmpty;

    // ============================================================
    // Queues
    // ============================================================
    // Full input queue drops the byte
    byteFifo inQueue (
        .clk(clk), .arstN(arstN), .push(inPush), .wdata(inData), .pop(cmdTake),
        .rdata(cmd), .full(), .empty(inEmpty)
    );

    byteFifo outQueue (
        .clk(clk), .arstN(arstN), .push(outPush), .wdata(outWData), .pop(outPop),
        .rdata(outRData), .full(outFull), .empty(outEmpty)
    );

    // ============================================================
    // Link, framing, control, memory
    // ============================================================
    serialShifter shifter (
        .clk(clk), .arstN(arstN), .debugCs(debugCs), .debugDi(debugDi),
        .debugDo(debugDo), .inPush(inPush), .inData(inData),
        .outData(outRData), .outEmpty(outEmpty), .outPop(outPop)
    );

    msgFramer framer (
        .clk(clk), .arstN(arstN), .msg(msg), .msgLen(msgLen), .outFull(outFull),
        .msgTake(msgTake), .outPush(outPush), .outData(outWData)
    );

    cmdController controller (
        .clk(clk), .arstN(arstN), .cmd(cmd), .cmdReady(cmdReady), .cmdTake(cmdTake),
        .msg(msg), .msgLen(msgLen), .msgTake(msgTake), .ledOn(ledOn), .mem(memBus)
    );

    patternMem memory (
        .clk(clk), .arstN(arstN), .mem(memBus)
    );

endmodule

`default_nettype wire

// ==== verification/debugTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugTb;

    // ============================================================
    // Run length and watchdog
    // ============================================================
    localparam int numCmds   = 40;
    // Covers the fill pass of about 1024 cycles
    localparam int idleBytes = 160;
    localparam int maxGap    = 5;
    localparam int wordCount = 1024;
    localparam int chunkMax  = 127;
    // Full memory read with frame bytes plus read gaps and latency per chunk
    localparam int readMemBytes = 9 * (2 + 2 * chunkMax) + 9 * 24;
    // Worst case has every command a memory read
    localparam int worstBytes   = idleBytes + numCmds * (maxGap + 1 + readMemBytes);
    localparam longint watchdogNs = longint'(worstBytes) * 8 * 3 / 2 * 20;

    logic clk;
    logic arstN;
    logic debugCs;
    logic debugDi;
    wire  debugDo;
    wire  ledOn;

    // Last frame seen by the host
    logic [7:0] frameCmd;
    logic [7:0] frameCnt;
    logic [7:0] frameData [256];

    // Expected LED and test bookkeeping
    logic  ledModel;
    string testName;
    int    testErrors;
    int    testsRun;
    int    testsFailed;

    debugTop UUT (
        .clk(clk), .arstN(arstN), .debugCs(debugCs), .debugDi(debugDi),
        .debugDo(debugDo), .ledOn(ledOn)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // ============================================================
    // Host link model
    // ============================================================
    // One byte each way with MSB first
    task automatic xferByte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        rx = 8'h00;
        for (i = 7; i >= 0; i--) begin
            @(negedge clk);
            debugCs = 1'b1;
            debugDi = tx[i];
            @(posedge clk);
            rx = {rx[6:0], debugDo};
        end
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            testErrors++;
            $display("** Error: %s, %s: expected 0x%0h, actual 0x%0h",
                     testName, what, expected, actual);
        end
    endtask

    // Idle filler where nothing may come back
    task automatic sendIdle(input int count);
        logic [7:0] rx;
        repeat (count) begin
            xferByte(8'h00, rx);
            checkValue("idle byte", 0, int'(rx));
        end
    endtask

    // Skip zeros between frames, then command, count and payload
    task automatic readFrame();
        logic [7:0] rx;
        int         i;
        rx = 8'h00;
        while (rx == 8'h00) begin
            xferByte(8'h00, rx);
        end
        frameCmd = rx;
        xferByte(8'h00, rx);
        frameCnt = rx;
        for (i = 0; i < int'(frameCnt); i++) begin
            xferByte(8'h00, rx);
            frameData[i] = rx;
        end
    endtask

    // ============================================================
    // Reference model
    // ============================================================
    function automatic logic [15:0] refWord(input int addr);
        return addr[15:0] ^ 16'hA5C3;
    endfunction

    // Echo payload counts down from 0xFF to 0x01
    task automatic checkEcho(input logic [7:0] code);
        int i;
        readFrame();
        checkValue("command byte", int'(code), int'(frameCmd));
        checkValue("count byte", 255, int'(frameCnt));
        for (i = 0; i < int'(frameCnt); i++) begin
            checkValue($sformatf("payload %0d", i), 255 - i, int'(frameData[i]));
        end
    endtask

    // Chunks of up to 127 words sent low byte first until all words are done
    task automatic checkReadMem();
        int          addr;
        int          n;
        int          k;
        logic [15:0] w;
        addr = 0;
        while (addr < wordCount) begin
            n = (wordCount - addr > chunkMax) ? chunkMax : wordCount - addr;
            readFrame();
            checkValue("command byte", 'h82, int'(frameCmd));
            checkValue("count byte", 2 * n, int'(frameCnt));
            for (k = 0; k < n; k++) begin
                w = refWord(addr + k);
                checkValue($sformatf("word %0d low", addr + k), int'(w[7:0]),
                           int'(frameData[2 * k]));
                checkValue($sformatf("word %0d high", addr + k), int'(w[15:8]),
                           int'(frameData[2 * k + 1]));
            end
            addr += n;
        end
    endtask

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d mismatches", testName, testErrors);
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        logic [7:0] code;
        logic [7:0] rx;
        int         pick;
        int         t;
        clk         = 1'b0;
        arstN       = 1'b0;
        debugCs     = 1'b0;
        debugDi     = 1'b0;
        ledModel    = 1'b0;
        testsRun    = 0;
        testsFailed = 0;
        void'($urandom(32'h481d86fb));
        repeat (16) @(negedge clk);
        arstN = 1'b1;

        // Link idles with zeros through the fill pass
        beginTest("idleAfterReset");
        sendIdle(idleBytes);
        checkValue("ledOn", 0, int'(ledOn));
        finishTest();

        for (t = 0; t < numCmds; t++) begin
            pick = $urandom_range(0, 15);
            // Memory read is rare with one forced halfway
            if (t == numCmds / 2 || pick == 0) begin
                code = 8'h82;
            end else if (pick < 5) begin
                code = 8'h81;
            end else if (pick < 9) begin
                code = 8'h80;
            end else begin
                // Any nonzero code outside 0x80 to 0x82
                code = 8'($urandom_range(1, 252));
                if (code >= 8'h80) begin
                    code = code + 8'd3;
                end
            end
            beginTest($sformatf("cmd%0d code 0x%02h", t, code));
            sendIdle(int'($urandom_range(0, maxGap)));
            xferByte(code, rx);
            checkValue("byte during command", 0, int'(rx));
            if (code == 8'h82) begin
                checkReadMem();
            end else begin
                checkEcho(code);
            end
            if (code == 8'h81) begin
                ledModel = 1'b1;
            end else if (code == 8'h80) begin
                ledModel = 1'b0;
            end
            checkValue("ledOn", int'(ledModel), int'(ledOn));
            finishTest();
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Ends a run whose reply never completes
    initial begin
        #(watchdogNs);
        $display("watchdog expired after %0d ns, a reply never finished", watchdogNs);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/debugPkg.sv
verilog/memReqIf.sv
verilog/byteFifo.sv
verilog/serialShifter.sv
verilog/msgFramer.sv
verilog/patternMem.sv
verilog/cmdController.sv
verilog/debugTop.sv
verification/debugTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --top-module debugTb -f sources.f -o debugSim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/debugSim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
[ -s sim.log ] || { echo "empty simulation log"; exit 1; }
grep -q "sim failed" sim.log && exit 1 || exit 0
